// File: all.f
idPkg.sv
regFile.sv
decodeControl.sv
immediateUnit.sv
idExReg.sv
idStage.sv
tbIdStage.sv

// File: decodeControl.sv
// Opcode decoder
// Register read addresses, destination register
// Execute, memory and write-back control levels
// PC redirect and alternate-PC source select

`timescale 1ns/1ps

module decodeControl (
  input  logic [idPkg::instrWidth-1:0]   instr,
  output logic [idPkg::regAddrWidth-1:0] readAddr1,
  output logic [idPkg::regAddrWidth-1:0] readAddr2,
  output logic [idPkg::regAddrWidth-1:0] destReg,
  output idPkg::aluOpT                   aluOp,
  output logic                           aluSrc2Imm,
  output logic                           memWrite,
  output logic                           memEnable,
  output logic                           memToReg,
  output logic                           regWrite,
  output logic                           linkSelect,
  output logic                           pcSelect,
  output idPkg::targetSelT               targetSel
);

  import idPkg::*;

  opcodeT                  opcode;
  logic [regAddrWidth-1:0] rdField;
  logic [regAddrWidth-1:0] rsField;
  logic [regAddrWidth-1:0] rtField;
  logic [condWidth-1:0]    condField;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  assign opcode    = opcodeT'(instr[opcodeLsb +: opcodeWidth]);
  assign rdField   = instr[rdLsb +: regAddrWidth];
  assign rsField   = instr[rsLsb +: regAddrWidth];
  assign rtField   = instr[rtLsb +: regAddrWidth];
  // Branch condition shares the rd bits
  assign condField = instr[rdLsb +: condWidth];

  // Source 1 is always rs
  assign readAddr1 = rsField;

  // Store data comes from rd
  assign readAddr2 = (opcode == opSw) ? rdField : rtField;

  // Link value goes to r15
  assign destReg   = (opcode == opJal) ? linkReg : rdField;

  //////////////////////////////////////////////////
  // Control table
  //////////////////////////////////////////////////

  always_comb
  begin
    // Everything inactive unless the opcode says otherwise
    aluOp      = aluAdd;
    aluSrc2Imm = 1'b0;
    memWrite   = 1'b0;
    memEnable  = 1'b0;
    memToReg   = 1'b0;
    regWrite   = 1'b0;
    linkSelect = 1'b0;
    pcSelect   = 1'b0;
    targetSel  = tgtBranch;

    case (opcode)
      // Register-register ALU ops
      opAdd, opSub, opAnd, opOr:
      begin
        aluOp    = aluOpT'(opcode[aluOpWidth-1:0]);
        regWrite = 1'b1;
      end

      // Shifts and rotate take the amount from the short immediate
      opSll, opSrl, opSra, opRl:
      begin
        aluOp      = aluOpT'(opcode[aluOpWidth-1:0]);
        aluSrc2Imm = 1'b1;
        regWrite   = 1'b1;
      end

      // Address is rs plus immediate
      opLw:
      begin
        aluSrc2Imm = 1'b1;
        memEnable  = 1'b1;
        memToReg   = 1'b1;
        regWrite   = 1'b1;
      end

      opSw:
      begin
        aluSrc2Imm = 1'b1;
        memEnable  = 1'b1;
        memWrite   = 1'b1;
      end

      // No flags here, only the always code is taken
      opB:
      begin
        targetSel = tgtBranch;
        pcSelect  = (condField == condAlways);
      end

      // Jump and write return address to r15
      opJal:
      begin
        targetSel  = tgtJump;
        pcSelect   = 1'b1;
        regWrite   = 1'b1;
        linkSelect = 1'b1;
      end

      // Target from rs
      opJr:
      begin
        targetSel = tgtReg;
        pcSelect  = 1'b1;
      end

      // Unsupported opcodes behave as no-ops
      opLhb, opLlb, opExec:
      begin
        aluOp = aluAdd;
      end

      default:
      begin
        aluOp = aluAdd;
      end
    endcase
  end

  // A store never reaches memory without the enable
  always_comb
  begin
    storeHasEnable: assert final (!memWrite || memEnable)
      else $error("decodeControl: memWrite without memEnable, opcode %0d", opcode);
  end

endmodule

// File: idExReg.sv
// ID/EX pipeline register
// Carries PC, operands, immediate, destination and controls to execute
// Cleared asynchronously, loads every cycle

`timescale 1ns/1ps

module idExReg (
  input  logic                           Clk,
  input  logic                           rstN,
  // Data from decode
  input  logic [idPkg::dataWidth-1:0]    pcPlus1,
  input  logic [idPkg::dataWidth-1:0]    readData1,
  input  logic [idPkg::dataWidth-1:0]    readData2,
  input  logic [idPkg::dataWidth-1:0]    immediate,
  input  logic [idPkg::regAddrWidth-1:0] destReg,
  // Controls from decode
  input  idPkg::aluOpT                   aluOp,
  input  logic                           aluSrc2Imm,
  input  logic                           memWrite,
  input  logic                           memEnable,
  input  logic                           memToReg,
  input  logic                           regWrite,
  input  logic                           linkSelect,
  // Execute side
  output logic [idPkg::dataWidth-1:0]    exPcPlus1,
  output logic [idPkg::dataWidth-1:0]    exReadData1,
  output logic [idPkg::dataWidth-1:0]    exReadData2,
  output logic [idPkg::dataWidth-1:0]    exImmediate,
  output logic [idPkg::regAddrWidth-1:0] exDestReg,
  output idPkg::aluOpT                   exAluOp,
  output logic                           exAluSrc2Imm,
  output logic                           exMemWrite,
  output logic                           exMemEnable,
  output logic                           exMemToReg,
  output logic                           exRegWrite,
  output logic                           exLinkSelect
);

  import idPkg::*;

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      // Payload
      exPcPlus1    <= '0;
      exReadData1  <= '0;
      exReadData2  <= '0;
      exImmediate  <= '0;
      exDestReg    <= '0;
      // Controls idle, ALU defaults to add
      exAluOp      <= aluAdd;
      exAluSrc2Imm <= 1'b0;
      exMemWrite   <= 1'b0;
      exMemEnable  <= 1'b0;
      exMemToReg   <= 1'b0;
      exRegWrite   <= 1'b0;
      exLinkSelect <= 1'b0;
    end
    else
    begin
      exPcPlus1    <= pcPlus1;
      exReadData1  <= readData1;
      exReadData2  <= readData2;
      exImmediate  <= immediate;
      exDestReg    <= destReg;
      exAluOp      <= aluOp;
      exAluSrc2Imm <= aluSrc2Imm;
      exMemWrite   <= memWrite;
      exMemEnable  <= memEnable;
      exMemToReg   <= memToReg;
      exRegWrite   <= regWrite;
      exLinkSelect <= linkSelect;
    end
  end

  // Load data must have somewhere to go in write-back
  loadWritesBack: assert property (
    @(posedge Clk) disable iff (!rstN)
    exMemToReg |-> exRegWrite
  ) else $error("idExReg: exMemToReg set without exRegWrite");

endmodule

// File: idPkg.sv
// Shared definitions for the instruction-decode stage
// Widths, instruction field positions and special register numbers
// Opcode, ALU operation and alternate-PC source enums

package idPkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data path and PC
  localparam int dataWidth    = 16;
  localparam int instrWidth   = 16;

  // Register file geometry
  localparam int regAddrWidth = 4;
  localparam int numRegs      = 16;

  // Encoded field widths
  localparam int opcodeWidth   = 4;
  localparam int aluOpWidth    = 3;
  localparam int condWidth     = 4;
  localparam int shortImmWidth = 4;
  localparam int offsetWidth   = 8;
  localparam int jumpAddrWidth = 12;

  //////////////////////////////////////////////////
  // Instruction field positions
  //////////////////////////////////////////////////

  // Low bit of each field, read upward by its width
  localparam int opcodeLsb = 12;
  // rd, or branch condition
  localparam int rdLsb     = 8;
  localparam int rsLsb     = 4;
  // rt, or short immediate
  localparam int rtLsb     = 0;

  //////////////////////////////////////////////////
  // Special registers and codes
  //////////////////////////////////////////////////

  // Jump-and-link target register
  localparam logic [regAddrWidth-1:0] linkReg  = 4'd15;
  // Hardwired zero
  localparam logic [regAddrWidth-1:0] zeroReg  = 4'd0;
  // Only branch condition that redirects
  localparam logic [condWidth-1:0] condAlways  = 4'b1111;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic [opcodeWidth-1:0] {
    opAdd  = 4'd0,  opSub = 4'd1,  opAnd = 4'd2,  opOr   = 4'd3,
    opSll  = 4'd4,  opSrl = 4'd5,  opSra = 4'd6,  opRl   = 4'd7,
    opLw   = 4'd8,  opSw  = 4'd9,  opLhb = 4'd10, opLlb  = 4'd11,
    opB    = 4'd12, opJal = 4'd13, opJr  = 4'd14, opExec = 4'd15
  } opcodeT;

  // Same numbering as the low three opcode bits of the ALU group
  typedef enum logic [aluOpWidth-1:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluSll, aluSrl, aluSra, aluRl
  } aluOpT;

  // Alternate-PC source
  typedef enum logic [1:0] {
    tgtBranch, tgtJump, tgtReg
  } targetSelT;

endpackage

// File: idStage.sv
// Instruction-decode stage top level
// Register file, opcode decoder, immediate unit and ID/EX register

`timescale 1ns/1ps

module idStage (
  input  logic                           Clk,
  input  logic                           rstN,
  // Fetch side
  input  logic [idPkg::instrWidth-1:0]   instr,
  input  logic [idPkg::dataWidth-1:0]    pcPlus1,
  // Write-back port
  input  logic                           wbWriteEnable,
  input  logic [idPkg::regAddrWidth-1:0] wbWriteAddr,
  input  logic [idPkg::dataWidth-1:0]    wbWriteData,
  // PC redirect, same cycle
  output logic [idPkg::dataWidth-1:0]    altPc,
  output logic                           pcSelect,
  // Execute side, one cycle later
  output logic [idPkg::dataWidth-1:0]    exPcPlus1,
  output logic [idPkg::dataWidth-1:0]    exReadData1,
  output logic [idPkg::dataWidth-1:0]    exReadData2,
  output logic [idPkg::dataWidth-1:0]    exImmediate,
  output logic [idPkg::regAddrWidth-1:0] exDestReg,
  output idPkg::aluOpT                   exAluOp,
  output logic                           exAluSrc2Imm,
  output logic                           exMemWrite,
  output logic                           exMemEnable,
  output logic                           exMemToReg,
  output logic                           exRegWrite,
  output logic                           exLinkSelect
);

  import idPkg::*;

  // Register file addressing and data
  logic [regAddrWidth-1:0] readAddr1;
  logic [regAddrWidth-1:0] readAddr2;
  logic [dataWidth-1:0]    readData1;
  logic [dataWidth-1:0]    readData2;

  // Decoded fields and controls
  logic [regAddrWidth-1:0] destReg;
  aluOpT                   aluOp;
  logic                    aluSrc2Imm;
  logic                    memWrite;
  logic                    memEnable;
  logic                    memToReg;
  logic                    regWrite;
  logic                    linkSelect;
  targetSelT               targetSel;
  logic [dataWidth-1:0]    immediate;

  regFile regFile_i (
    .Clk         (Clk),
    .rstN        (rstN),
    .writeEnable (wbWriteEnable),
    .writeAddr   (wbWriteAddr),
    .writeData   (wbWriteData),
    .readAddr1   (readAddr1),
    .readAddr2   (readAddr2),
    .readData1   (readData1),
    .readData2   (readData2)
  );

  decodeControl decodeControl_i (
    .instr      (instr),
    .readAddr1  (readAddr1),
    .readAddr2  (readAddr2),
    .destReg    (destReg),
    .aluOp      (aluOp),
    .aluSrc2Imm (aluSrc2Imm),
    .memWrite   (memWrite),
    .memEnable  (memEnable),
    .memToReg   (memToReg),
    .regWrite   (regWrite),
    .linkSelect (linkSelect),
    .pcSelect   (pcSelect),
    .targetSel  (targetSel)
  );

  // Jump-register target is rs, read on port 1
  immediateUnit immediateUnit_i (
    .instr     (instr),
    .pcPlus1   (pcPlus1),
    .regData   (readData1),
    .targetSel (targetSel),
    .immediate (immediate),
    .altPc     (altPc)
  );

  idExReg idExReg_i (
    .Clk          (Clk),
    .rstN         (rstN),
    .pcPlus1      (pcPlus1),
    .readData1    (readData1),
    .readData2    (readData2),
    .immediate    (immediate),
    .destReg      (destReg),
    .aluOp        (aluOp),
    .aluSrc2Imm   (aluSrc2Imm),
    .memWrite     (memWrite),
    .memEnable    (memEnable),
    .memToReg     (memToReg),
    .regWrite     (regWrite),
    .linkSelect   (linkSelect),
    .exPcPlus1    (exPcPlus1),
    .exReadData1  (exReadData1),
    .exReadData2  (exReadData2),
    .exImmediate  (exImmediate),
    .exDestReg    (exDestReg),
    .exAluOp      (exAluOp),
    .exAluSrc2Imm (exAluSrc2Imm),
    .exMemWrite   (exMemWrite),
    .exMemEnable  (exMemEnable),
    .exMemToReg   (exMemToReg),
    .exRegWrite   (exRegWrite),
    .exLinkSelect (exLinkSelect)
  );

endmodule

// File: immediateUnit.sv
// Immediate extension for the execute stage
// Alternate-PC target for branch, jump and jump-register

`timescale 1ns/1ps

module immediateUnit (
  input  logic [idPkg::instrWidth-1:0] instr,
  input  logic [idPkg::dataWidth-1:0]  pcPlus1,
  input  logic [idPkg::dataWidth-1:0]  regData,
  input  idPkg::targetSelT             targetSel,
  output logic [idPkg::dataWidth-1:0]  immediate,
  output logic [idPkg::dataWidth-1:0]  altPc
);

  import idPkg::*;

  logic [dataWidth-1:0] branchOffset;
  logic [dataWidth-1:0] jumpTarget;

  // Short immediate, sign extended from bit 3
  assign immediate = {{(dataWidth-shortImmWidth){instr[rtLsb+shortImmWidth-1]}},
                      instr[rtLsb +: shortImmWidth]};

  // 8-bit branch offset, sign extended
  assign branchOffset = {{(dataWidth-offsetWidth){instr[offsetWidth-1]}},
                         instr[offsetWidth-1:0]};

  // Absolute jump address, upper bits zero
  assign jumpTarget = {{(dataWidth-jumpAddrWidth){1'b0}}, instr[jumpAddrWidth-1:0]};

  //////////////////////////////////////////////////
  // Alternate PC mux
  //////////////////////////////////////////////////

  always_comb
  begin
    altPc = pcPlus1 + branchOffset;
    case (targetSel)
      tgtJump:   altPc = jumpTarget;
      tgtReg:    altPc = regData;
      default:   altPc = pcPlus1 + branchOffset;
    endcase
  end

  // Decoder only ever drives a named source
  always_comb
  begin
    targetSelNamed: assert final (targetSel inside {tgtBranch, tgtJump, tgtReg})
      else $error("immediateUnit: targetSel holds %b", targetSel);
  end

endmodule

// File: regFile.sv
// Register file, 16 x 16 bit
// Asynchronous clear, strobed write port, two combinational read ports
// Register 0 ignores writes and always reads zero

`timescale 1ns/1ps

module regFile (
  input  logic                           Clk,
  input  logic                           rstN,
  input  logic                           writeEnable,
  input  logic [idPkg::regAddrWidth-1:0] writeAddr,
  input  logic [idPkg::dataWidth-1:0]    writeData,
  input  logic [idPkg::regAddrWidth-1:0] readAddr1,
  input  logic [idPkg::regAddrWidth-1:0] readAddr2,
  output logic [idPkg::dataWidth-1:0]    readData1,
  output logic [idPkg::dataWidth-1:0]    readData2
);

  import idPkg::*;

  // Storage array
  logic [dataWidth-1:0] regs [numRegs];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      // Clear every entry
      for (int i = 0; i < numRegs; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeEnable && (writeAddr != zeroReg))
    begin
      regs[writeAddr] <= writeData;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // No bypass, a write shows up after its edge
  assign readData1 = regs[readAddr1];
  assign readData2 = regs[readAddr2];

  // Zero register stays clear whatever the write-back stage sends
  zeroRegStaysZero: assert property (
    @(posedge Clk) disable iff (!rstN)
    regs[zeroReg] == '0
  ) else $error("regFile: register %0d holds %h", zeroReg, regs[zeroReg]);

endmodule

// File: tbIdStage.sv
// Testbench for the instruction-decode stage
// Clock, reset, reference register model and random stimulus
// Concurrent checks on the redirect and the ID/EX outputs

`timescale 1ns/1ps

module tbIdStage;

  import idPkg::*;

  // DUT inputs
  logic                    Clk;
  logic                    rstN;
  logic [instrWidth-1:0]   instr;
  logic [dataWidth-1:0]    pcPlus1;
  logic                    wbWriteEnable;
  logic [regAddrWidth-1:0] wbWriteAddr;
  logic [dataWidth-1:0]    wbWriteData;

  // DUT outputs
  logic [dataWidth-1:0]    altPc;
  logic                    pcSelect;
  logic [dataWidth-1:0]    exPcPlus1;
  logic [dataWidth-1:0]    exReadData1;
  logic [dataWidth-1:0]    exReadData2;
  logic [dataWidth-1:0]    exImmediate;
  logic [regAddrWidth-1:0] exDestReg;
  aluOpT                   exAluOp;
  logic                    exAluSrc2Imm;
  logic                    exMemWrite;
  logic                    exMemEnable;
  logic                    exMemToReg;
  logic                    exRegWrite;
  logic                    exLinkSelect;

  // Reference register contents
  logic [dataWidth-1:0]    model [numRegs];

  // Expected values for the instruction on the inputs
  opcodeT                  curOp;
  logic [8:0]              expCtrl;
  logic [regAddrWidth-1:0] expDest;
  logic [dataWidth-1:0]    expImm;
  logic [dataWidth-1:0]    expRd1;
  logic [dataWidth-1:0]    expRd2;
  logic                    expPcSel;
  logic [dataWidth-1:0]    expAltPc;
  logic                    isRedirectOp;

  // Same values held for one edge to meet the ex outputs
  logic                    savedValid;
  logic [8:0]              savedCtrl;
  logic [regAddrWidth-1:0] savedDest;
  logic [dataWidth-1:0]    savedImm;
  logic [dataWidth-1:0]    savedRd1;
  logic [dataWidth-1:0]    savedRd2;
  logic [dataWidth-1:0]    savedPc;

  logic [76:0]             exAll;
  logic [8:0]              exCtrl;

  int resetErrors = 0;
  int regErrors   = 0;
  int ctrlErrors  = 0;
  int pcErrors    = 0;
  int cycleCount  = 0;

  idStage dut_i (.*);

  // 4 ns period
  always #2 Clk = ~Clk;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Control bits from the msb down
  // aluOp(3) src2Imm memWrite memEnable memToReg regWrite link
  function automatic logic [8:0] controlsFor(input opcodeT op);
    logic [8:0] c;
    c = '0;
    case (op)
      opAdd: c = {aluAdd, 6'b000010};
      opSub: c = {aluSub, 6'b000010};
      opAnd: c = {aluAnd, 6'b000010};
      opOr:  c = {aluOr,  6'b000010};
      opSll: c = {aluSll, 6'b100010};
      opSrl: c = {aluSrl, 6'b100010};
      opSra: c = {aluSra, 6'b100010};
      opRl:  c = {aluRl,  6'b100010};
      opLw:  c = {aluAdd, 6'b101110};
      opSw:  c = {aluAdd, 6'b111000};
      opJal: c = {aluAdd, 6'b000011};
      // Branch, jr and the dropped opcodes leave every level low
      default: c = '0;
    endcase
    return c;
  endfunction

  // Mirrors write-back port writes except to r0
  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < numRegs; i++)
      begin
        model[i] <= '0;
      end
    end
    else if (wbWriteEnable && (wbWriteAddr != 4'd0))
    begin
      model[wbWriteAddr] <= wbWriteData;
    end
  end

  assign curOp    = opcodeT'(instr[15:12]);
  assign expCtrl  = controlsFor(curOp);
  assign expDest  = (curOp == opJal) ? 4'd15 : instr[11:8];
  assign expImm   = {{12{instr[3]}}, instr[3:0]};
  assign expRd1   = model[instr[7:4]];
  // Store data register sits in the rd field
  assign expRd2   = model[(curOp == opSw) ? instr[11:8] : instr[3:0]];
  assign expPcSel = (curOp == opJal) || (curOp == opJr) ||
                    ((curOp == opB) && (instr[11:8] == 4'hF));
  assign isRedirectOp = (curOp == opB) || (curOp == opJal) || (curOp == opJr);

  always_comb
  begin
    case (curOp)
      opJal:   expAltPc = {4'b0000, instr[11:0]};
      opJr:    expAltPc = model[instr[7:4]];
      default: expAltPc = pcPlus1 + {{8{instr[7]}}, instr[7:0]};
    endcase
  end

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      savedValid <= 1'b0;
    end
    else
    begin
      savedValid <= 1'b1;
      savedCtrl  <= expCtrl;
      savedDest  <= expDest;
      savedImm   <= expImm;
      savedRd1   <= expRd1;
      savedRd2   <= expRd2;
      savedPc    <= pcPlus1;
    end
  end

  assign exCtrl = {exAluOp, exAluSrc2Imm, exMemWrite, exMemEnable, exMemToReg, exRegWrite,
                   exLinkSelect};
  assign exAll  = {exPcPlus1, exReadData1, exReadData2, exImmediate, exDestReg, exCtrl};

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Held clear in reset and at the first edge out of it
  resetClear: assert property (@(posedge Clk) (!rstN || $rose(rstN)) |-> (exAll == '0))
    else
    begin
      resetErrors++;
      $display("[ERROR] reset expected %h actual %h", 77'h0, $sampled(exAll));
    end

  readPort1: assert property (@(posedge Clk) disable iff (!rstN)
    savedValid |-> (exReadData1 == savedRd1))
    else
    begin
      regErrors++;
      $display("[ERROR] regRead1 expected %h actual %h", $sampled(savedRd1),
               $sampled(exReadData1));
    end

  readPort2: assert property (@(posedge Clk) disable iff (!rstN)
    savedValid |-> (exReadData2 == savedRd2))
    else
    begin
      regErrors++;
      $display("[ERROR] regRead2 expected %h actual %h", $sampled(savedRd2),
               $sampled(exReadData2));
    end

  controlTable: assert property (@(posedge Clk) disable iff (!rstN)
    savedValid |-> (exCtrl == savedCtrl))
    else
    begin
      ctrlErrors++;
      $display("[ERROR] controls expected %b actual %b", $sampled(savedCtrl), $sampled(exCtrl));
    end

  destination: assert property (@(posedge Clk) disable iff (!rstN)
    savedValid |-> (exDestReg == savedDest))
    else
    begin
      ctrlErrors++;
      $display("[ERROR] destReg expected %0d actual %0d", $sampled(savedDest),
               $sampled(exDestReg));
    end

  immediateExt: assert property (@(posedge Clk) disable iff (!rstN)
    savedValid |-> (exImmediate == savedImm))
    else
    begin
      ctrlErrors++;
      $display("[ERROR] immediate expected %h actual %h", $sampled(savedImm),
               $sampled(exImmediate));
    end

  // PC counts up so a hole or a repeat shows here
  pipelineOrder: assert property (@(posedge Clk) disable iff (!rstN)
    savedValid |-> (exPcPlus1 == savedPc))
    else
    begin
      ctrlErrors++;
      $display("[ERROR] pcPlus1 expected %h actual %h", $sampled(savedPc), $sampled(exPcPlus1));
    end

  redirect: assert property (@(posedge Clk) disable iff (!rstN) pcSelect == expPcSel)
    else
    begin
      pcErrors++;
      $display("[ERROR] pcSelect expected %b actual %b", $sampled(expPcSel), $sampled(pcSelect));
    end

  target: assert property (@(posedge Clk) disable iff (!rstN)
    isRedirectOp |-> (altPc == expAltPc))
    else
    begin
      pcErrors++;
      $display("[ERROR] altPc expected %h actual %h", $sampled(expAltPc), $sampled(altPc));
    end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  function automatic logic [dataWidth-1:0] randWord();
    return 16'($urandom);
  endfunction

  // One instruction per falling edge with the PC counting up
  task automatic driveCycle(input logic [15:0] ins, input logic we,
                            input logic [3:0] wa, input logic [15:0] wd);
    @(negedge Clk);
    instr         = ins;
    pcPlus1       = pcPlus1 + 16'd1;
    wbWriteEnable = we;
    wbWriteAddr   = wa;
    wbWriteData   = wd;
  endtask

  // Run limit at about three times the test length
  always @(posedge Clk)
  begin
    cycleCount++;
    if (cycleCount >= 2000)
    begin
      $display("Timeout: the run did not finish within 2000 cycles");
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    int total;
    void'($urandom(42));
    Clk           = 1'b0;
    rstN          = 1'b0;
    instr         = '0;
    pcPlus1       = randWord();
    wbWriteEnable = 1'b0;
    wbWriteAddr   = '0;
    wbWriteData   = '0;
    repeat (4) @(posedge Clk);
    @(negedge Clk);
    rstN = 1'b1;

    // Fill every register including r0 under no-op instructions
    for (int r = 0; r < 16; r++)
    begin
      driveCycle({opLhb, 12'(r)}, 1'b1, 4'(r), randWord());
    end
    // Read each register back through adds
    for (int r = 0; r < 16; r++)
    begin
      driveCycle({opAdd, 4'(r), 4'(r), 4'(15 - r)}, 1'b0, 4'd0, 16'd0);
    end
    // Reads racing writes with no bypass expected
    repeat (32)
    begin
      driveCycle({opAdd, 12'($urandom)}, 1'b1, 4'($urandom), randWord());
    end

    // Every opcode a few times
    for (int k = 0; k < 64; k++)
    begin
      driveCycle({4'(k % 16), 12'($urandom)}, 1'b0, 4'd0, 16'd0);
    end

    // Taken and untaken branches followed by jumps
    repeat (16)
    begin
      driveCycle({opB, 4'hF, 8'($urandom)}, 1'b0, 4'd0, 16'd0);
      driveCycle({opB, 4'($urandom_range(14, 0)), 8'($urandom)}, 1'b0, 4'd0, 16'd0);
      driveCycle({opJal, 12'($urandom)}, 1'b1, 4'($urandom), randWord());
      driveCycle({opJr, 12'($urandom)}, 1'b0, 4'd0, 16'd0);
    end

    // Back-to-back random traffic
    repeat (400)
    begin
      driveCycle(randWord(), 1'($urandom), 4'($urandom), randWord());
    end

    // Let the last instruction reach the ex outputs
    repeat (2)
    begin
      driveCycle({opLlb, 12'h000}, 1'b0, 4'd0, 16'd0);
    end
    @(negedge Clk);

    total = resetErrors + regErrors + ctrlErrors + pcErrors;
    $display("Errors: reset %0d, register %0d, control %0d, redirect %0d, total %0d",
             resetErrors, regErrors, ctrlErrors, pcErrors, total);
    if (total == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
